/* sha256_cfg.svh */
// Width and count settings shared by the packages, the RTL and the testbench; include before use
`ifndef SHA256_CFG_SVH
`define SHA256_CFG_SVH

// Rounds in one SHA-256 compression
`define SHA_ROUNDS 64

// Message block width
`define BLOCK_BITS 512

// Hash and chaining state width
`define DIGEST_BITS 256

// Salsa X buffer, four output blocks
`define XBUF_BITS 1024

// Low part of the nonce, nonce_msb sits on top
`define NONCE_CNT_BITS 28

`endif

/* sha256_pkg.sv */
// SHA-256 algorithm constants and word type, referenced by scoped name from the core and sequencer
`include "sha256_cfg.svh"

package sha256_pkg;

	typedef logic [31:0] sha_word_t;	// One SHA-256 word

	// H0 sits in the low word, matching the block word order
	localparam logic [`DIGEST_BITS-1:0] SHA_IV = {
		32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
		32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667
	};

	localparam sha_word_t SHA_K [`SHA_ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
		32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
		32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
		32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
		32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
		32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

endpackage

/* pbkdf_pkg.sv */
// PBKDF2 sequencer phase type, HMAC pad words and message padding tails used by the sequencer
`include "sha256_cfg.svh"

package pbkdf_pkg;

	typedef enum logic [5:0] {
		PH_IDLE,	// Waiting for the X buffer to drain
		PH_KEY1,	// Key hash, header words 0..15
		PH_KEY2,	// Key hash, header tail with nonce
		PH_IPAD1,	// Inner pad block
		PH_IPAD2,	// Inner hash over header as salt
		PH_OPAD,	// Outer pad block
		PH_BLK1,	// Output block, inner half
		PH_BLK2,	// Output block, outer half
		PH_XWAIT	// Lets x_pending rise before idle
	} pbkdf_phase_t;

	localparam logic [`DIGEST_BITS-1:0] IPAD_WORD = {32{8'h36}};
	localparam logic [`DIGEST_BITS-1:0] OPAD_WORD = {32{8'h5c}};

	// Words 4..15 after the last 16 header bytes, length 80 bytes
	localparam logic [383:0] HDR_TAIL_PAD = {32'h00000280, 320'd0, 32'h80000000};

	// Words 5..15 after header tail and block index, length 148 bytes
	localparam logic [351:0] BLOCK_PAD = {32'h000004a0, 288'd0, 32'h80000000};

	// Words 8..15 after the inner digest, length 96 bytes
	localparam logic [`BLOCK_BITS-`DIGEST_BITS-1:0] OUTER_PAD =
		{32'h00000300, 192'd0, 32'h80000000};

endpackage

/* hash_if.sv */
// Compression request and result bundle between the PBKDF2 sequencer and the SHA-256 core
`include "sha256_cfg.svh"

interface hash_if;

	logic                    start;	// One-cycle request strobe
	logic [`DIGEST_BITS-1:0] chain;	// Chaining state, H0 in low word
	logic [`BLOCK_BITS-1:0]  block;	// Message block, word 0 in low bits
	logic                    done;	// One cycle, digest valid
	logic [`DIGEST_BITS-1:0] digest;

	modport seq (output start, chain, block, input done, digest);

	modport core (input start, chain, block, output done, digest);

endinterface

/* sha256_core.sv */
// Iterative SHA-256 compression, one round per cycle, serving all hashes of the PBKDF2 sequencer
`include "sha256_cfg.svh"

module sha256_core (
	input logic hash_clk,
	input logic reset,
	hash_if.core hif
);

	localparam int RND_BITS = $clog2(`SHA_ROUNDS);

	sha256_pkg::sha_word_t v [8];	// Working vars a..h
	sha256_pkg::sha_word_t w [16];	// Rolling message schedule
	sha256_pkg::sha_word_t t1, t2, w_new;
	logic [RND_BITS-1:0] rnd;
	logic busy;

	function automatic sha256_pkg::sha_word_t rotr(input sha256_pkg::sha_word_t x, input int n);
		rotr = (x >> n) | (x << (32 - n));
	endfunction

	always_comb begin
		t1 = v[7] + (rotr(v[4], 6) ^ rotr(v[4], 11) ^ rotr(v[4], 25))	// h + S1(e)
			+ ((v[4] & v[5]) ^ (~v[4] & v[6]))	// Ch
			+ sha256_pkg::SHA_K[rnd] + w[0];
		t2 = (rotr(v[0], 2) ^ rotr(v[0], 13) ^ rotr(v[0], 22))	// S0(a)
			+ ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));	// Maj
		w_new = (rotr(w[14], 17) ^ rotr(w[14], 19) ^ (w[14] >> 10)) + w[9]
			+ (rotr(w[1], 7) ^ rotr(w[1], 18) ^ (w[1] >> 3)) + w[0];
	end

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			busy <= 1'b0;
			rnd <= '0;
			hif.done <= 1'b0;
		end else begin
			hif.done <= 1'b0;	// Strobe by default
			if (hif.start) begin
				busy <= 1'b1;
				rnd <= '0;
			end else if (busy) begin
				rnd <= rnd + 1'b1;
				if (rnd == RND_BITS'(`SHA_ROUNDS - 1)) begin
					busy <= 1'b0;
					hif.done <= 1'b1;	// Cycle 65 of the request
				end
			end
		end
	end

	always_ff @(posedge hash_clk) begin
		if (hif.start) begin
			for (int i = 0; i < 8; i++)
				v[i] <= hif.chain[32*i +: 32];
			for (int i = 0; i < 16; i++)
				w[i] <= hif.block[32*i +: 32];
		end else if (busy) begin
			v[0] <= t1 + t2;
			v[1] <= v[0];
			v[2] <= v[1];
			v[3] <= v[2];
			v[4] <= v[3] + t1;
			v[5] <= v[4];
			v[6] <= v[5];
			v[7] <= v[6];
			for (int i = 0; i < 15; i++)
				w[i] <= w[i+1];
			w[15] <= w_new;	// Next schedule word
		end
	end

	// Feed-forward add, chain is still held in the done cycle
	always_comb begin
		for (int i = 0; i < 8; i++)
			hif.digest[32*i +: 32] = v[i] + hif.chain[32*i +: 32];
	end

endmodule

/* pbkdf_sequencer.sv */
// PBKDF2-HMAC-SHA256 control for the 80-byte header; issues 13 compressions per nonce job
`include "sha256_cfg.svh"

module pbkdf_sequencer (
	input  logic                    hash_clk,
	input  logic                    reset,
	input  logic [255:0]            data1,
	input  logic [255:0]            data2,
	input  logic [127:0]            data3,
	input  logic [3:0]              nonce_msb,
	input  logic                    loadnonce,
	input  logic                    x_pending,
	output logic [31:0]             nonce_out,
	output logic                    blk_strobe,
	output logic [`DIGEST_BITS-1:0] blk_data,
	output logic                    blk_last,
	hash_if.seq                     hif
);

	pbkdf_pkg::pbkdf_phase_t phase;
	logic [`NONCE_CNT_BITS-1:0] nonce_cnt;
	logic [31:0] job_nonce;	// Frozen at job start
	logic [`DIGEST_BITS-1:0] khash, ihash, ohash;
	logic [2:0] blkcnt;	// Output block 1..4

	assign nonce_out = {nonce_msb, nonce_cnt};

	// Inner message for output block n, header tail as salt plus block index
	function automatic logic [`BLOCK_BITS-1:0] blk_msg(input logic [2:0] n,
			input logic [31:0] nonce, input logic [95:0] hdr_tail);
		blk_msg = {pbkdf_pkg::BLOCK_PAD, 29'd0, n, nonce, hdr_tail};
	endfunction

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			phase <= pbkdf_pkg::PH_IDLE;
			hif.start <= 1'b0;
			blk_strobe <= 1'b0;
			blk_last <= 1'b0;
			blkcnt <= 3'd0;
			nonce_cnt <= '0;
		end else begin
			hif.start <= 1'b0;
			blk_strobe <= 1'b0;
			blk_last <= 1'b0;
			case (phase)
				pbkdf_pkg::PH_IDLE: if (!x_pending) begin
					job_nonce <= {nonce_msb, nonce_cnt};
					hif.chain <= sha256_pkg::SHA_IV;
					hif.block <= {data2, data1};	// Header is the password
					hif.start <= 1'b1;
					phase <= pbkdf_pkg::PH_KEY1;
				end
				pbkdf_pkg::PH_KEY1: if (hif.done) begin
					hif.chain <= hif.digest;
					hif.block <= {pbkdf_pkg::HDR_TAIL_PAD, job_nonce, data3[95:0]};
					hif.start <= 1'b1;
					phase <= pbkdf_pkg::PH_KEY2;
				end
				pbkdf_pkg::PH_KEY2: if (hif.done) begin
					khash <= hif.digest;	// Kept for the outer pad
					hif.chain <= sha256_pkg::SHA_IV;
					hif.block <= {pbkdf_pkg::IPAD_WORD, hif.digest ^ pbkdf_pkg::IPAD_WORD};
					hif.start <= 1'b1;
					phase <= pbkdf_pkg::PH_IPAD1;
				end
				pbkdf_pkg::PH_IPAD1: if (hif.done) begin
					hif.chain <= hif.digest;
					hif.block <= {data2, data1};	// Salt, first 64 bytes
					hif.start <= 1'b1;
					phase <= pbkdf_pkg::PH_IPAD2;
				end
				pbkdf_pkg::PH_IPAD2: if (hif.done) begin
					ihash <= hif.digest;
					hif.chain <= sha256_pkg::SHA_IV;
					hif.block <= {pbkdf_pkg::OPAD_WORD, khash ^ pbkdf_pkg::OPAD_WORD};
					hif.start <= 1'b1;
					phase <= pbkdf_pkg::PH_OPAD;
				end
				pbkdf_pkg::PH_OPAD: if (hif.done) begin
					ohash <= hif.digest;
					blkcnt <= 3'd1;
					hif.chain <= ihash;
					hif.block <= blk_msg(3'd1, job_nonce, data3[95:0]);
					hif.start <= 1'b1;
					phase <= pbkdf_pkg::PH_BLK1;
				end
				pbkdf_pkg::PH_BLK1: if (hif.done) begin
					hif.chain <= ohash;
					hif.block <= {pbkdf_pkg::OUTER_PAD, hif.digest};
					hif.start <= 1'b1;
					phase <= pbkdf_pkg::PH_BLK2;
				end
				pbkdf_pkg::PH_BLK2: if (hif.done) begin
					blk_strobe <= 1'b1;	// Hand block to the serializer
					blk_data <= hif.digest;
					if (blkcnt == 3'd4) begin
						blk_last <= 1'b1;
						nonce_cnt <= nonce_cnt + 1'b1;	// Next job's nonce
						phase <= pbkdf_pkg::PH_XWAIT;
					end else begin
						blkcnt <= blkcnt + 3'd1;
						hif.chain <= ihash;
						hif.block <= blk_msg(blkcnt + 3'd1, job_nonce, data3[95:0]);
						hif.start <= 1'b1;
						phase <= pbkdf_pkg::PH_BLK1;
					end
				end
				// x_pending is registered, one cycle passes before idle can see it
				pbkdf_pkg::PH_XWAIT: phase <= pbkdf_pkg::PH_IDLE;
				default: phase <= pbkdf_pkg::PH_IDLE;
			endcase
			if (loadnonce)
				nonce_cnt <= data3[96 +: `NONCE_CNT_BITS];	// Load wins over the step
		end
	end

endmodule

/* x_serializer.sv */
// Collects the four PBKDF2 output blocks into X and shifts it bit-serially to the salsa unit
`include "sha256_cfg.svh"

module x_serializer (
	input  logic                    hash_clk,
	input  logic                    reset,
	input  logic                    blk_strobe,
	input  logic [`DIGEST_BITS-1:0] blk_data,
	input  logic                    blk_last,
	input  logic                    salsa_busy,
	output logic                    x_pending,
	output logic                    salsa_din,
	output logic                    salsa_shift,
	output logic                    salsa_start
);

	logic [`XBUF_BITS-1:0] xbuf;
	logic [10:0] shift_cnt;	// Bits sent so far

	assign salsa_din = xbuf[`XBUF_BITS-1];	// MSB first

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			x_pending <= 1'b0;
			salsa_shift <= 1'b0;
			salsa_start <= 1'b0;
			shift_cnt <= '0;
		end else begin
			salsa_start <= 1'b0;
			if (blk_strobe && blk_last)
				x_pending <= 1'b1;	// Full X held
			if (salsa_shift) begin
				shift_cnt <= shift_cnt + 11'd1;
				if (shift_cnt == 11'(`XBUF_BITS - 1)) begin
					salsa_shift <= 1'b0;
					salsa_start <= 1'b1;	// Cycle after the last bit
					x_pending <= 1'b0;
				end
			end else if (x_pending && !salsa_busy) begin
				salsa_shift <= 1'b1;	// Salsa free, begin transfer
				shift_cnt <= '0;
			end
		end
	end

	// Newest block enters on top, first block ends up lowest
	always_ff @(posedge hash_clk) begin
		if (blk_strobe)
			xbuf <= {blk_data, xbuf[`XBUF_BITS-1:`DIGEST_BITS]};
		else if (salsa_shift)
			xbuf <= {xbuf[`XBUF_BITS-2:0], 1'b0};
	end

endmodule

/* pbkdf_engine.sv */
// Top level of the scrypt front half; header and nonce in, serial X out to the salsa unit
`include "sha256_cfg.svh"

module pbkdf_engine (
	input  logic         hash_clk,
	input  logic         reset,
	input  logic [255:0] data1,
	input  logic [255:0] data2,
	input  logic [127:0] data3,
	input  logic [3:0]   nonce_msb,
	input  logic         loadnonce,
	input  logic         salsa_busy,
	output logic [31:0]  nonce_out,
	output logic         salsa_din,
	output logic         salsa_shift,
	output logic         salsa_start
);

	logic                    blk_strobe;
	logic [`DIGEST_BITS-1:0] blk_data;
	logic                    blk_last;
	logic                    x_pending;	// Back-pressure to the sequencer

	hash_if hif ();

	sha256_core i_sha256_core (
		.hash_clk (hash_clk),
		.reset    (reset),
		.hif      (hif.core)
	);

	pbkdf_sequencer i_pbkdf_sequencer (
		.hash_clk   (hash_clk),
		.reset      (reset),
		.data1      (data1),
		.data2      (data2),
		.data3      (data3),
		.nonce_msb  (nonce_msb),
		.loadnonce  (loadnonce),
		.x_pending  (x_pending),
		.nonce_out  (nonce_out),
		.blk_strobe (blk_strobe),
		.blk_data   (blk_data),
		.blk_last   (blk_last),
		.hif        (hif.seq)
	);

	x_serializer i_x_serializer (
		.hash_clk    (hash_clk),
		.reset       (reset),
		.blk_strobe  (blk_strobe),
		.blk_data    (blk_data),
		.blk_last    (blk_last),
		.salsa_busy  (salsa_busy),
		.x_pending   (x_pending),
		.salsa_din   (salsa_din),
		.salsa_shift (salsa_shift),
		.salsa_start (salsa_start)
	);

endmodule

/* tb_pbkdf_engine.sv */
// Testbench for the PBKDF2 front half; runs a table of header jobs and checks each serial X transfer
`include "sha256_cfg.svh"

module tb_pbkdf_engine;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROWS = 4;
	localparam int CYCLE_LIMIT = ROWS * 3000 + 5;	// Job, busy hold and shift per row plus reset

	// Standard SHA-256 start value with H0 in the top word
	localparam logic [255:0] IV_BE = {32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};

	// Job table of header words, nonce top nibble, busy hold, load flag and expected job nonce
	localparam logic [255:0] TAB_D1 [ROWS] = '{
		256'h01000000_a3f1c2d4_5e6b7a89_9ab0cd1e_2f304152_63748596_a7b8c9da_ebfc0d1e,
		256'h02000000_11223344_55667788_99aabbcc_ddeeff00_13579bdf_2468ace0_0f1e2d3c,
		256'h02000000_deadbeef_cafef00d_01234567_89abcdef_fedcba98_76543210_5a5aa5a5,
		256'h03000000_0badc0de_feedface_31415926_53589793_23846264_33832795_02884197};
	localparam logic [255:0] TAB_D2 [ROWS] = '{
		256'h7c1b9e04_88aa33cc_4d5e6f70_81929394_a5b6c7d8_e9fa0b1c_2d3e4f50_61728394,
		256'h0a0b0c0d_1a1b1c1d_2a2b2c2d_3a3b3c3d_4a4b4c4d_5a5b5c5d_6a6b6c6d_7a7b7c7d,
		256'h93e1c0a7_55555555_aaaaaaaa_00ff00ff_ff00ff00_0f0f0f0f_f0f0f0f0_12481248,
		256'h27182818_28459045_23536028_74713526_62497757_24709369_99595749_66967627};
	localparam logic [127:0] TAB_D3 [ROWS] = '{
		128'h00000000_1d00ffff_5b8d8e21_c3a9b7f0,
		128'h1c0ffee0_1c1d0a0b_4e2f6a11_80706050,	// Load value c0ffee0
		128'h00000000_1b04864c_4f3c2a10_99887766,
		128'h7654321f_1a44b9f2_6d5c4b3a_0123abcd};	// Load value 654321f
	localparam logic [3:0] TAB_MSB [ROWS] = '{4'h3, 4'ha, 4'ha, 4'h5};
	localparam int TAB_HOLD [ROWS] = '{0, 1000, 300, 950};	// 1000 and 950 outlast the job
	localparam bit TAB_LOAD [ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};
	localparam logic [31:0] TAB_NONCE [ROWS] = '{32'h30000000, 32'hac0ffee0, 32'hac0ffee1,
		32'h5654321f};	// Row 0 runs on the reset count

	logic hash_clk, reset, loadnonce, salsa_busy;
	logic [255:0] data1, data2;
	logic [127:0] data3;
	logic [3:0] nonce_msb;
	logic [31:0] nonce_out;
	logic salsa_din, salsa_shift, salsa_start;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	logic [31:0] lfsr = 32'h4074;

	pbkdf_engine i_pbkdf_engine (
		.hash_clk    (hash_clk),
		.reset       (reset),
		.data1       (data1),
		.data2       (data2),
		.data3       (data3),
		.nonce_msb   (nonce_msb),
		.loadnonce   (loadnonce),
		.salsa_busy  (salsa_busy),
		.nonce_out   (nonce_out),
		.salsa_din   (salsa_din),
		.salsa_shift (salsa_shift),
		.salsa_start (salsa_start)
	);

	function automatic logic [31:0] ror(input logic [31:0] v, input int n);
		return (v >> n) | (v << (32 - n));
	endfunction

	// One SHA-256 compression in standard order with H0 and word 0 on top
	function automatic logic [255:0] compress(input logic [255:0] h, input logic [511:0] blk);
		logic [31:0] w [64];
		logic [31:0] a, b, c, d, e, f, g, hh, t1, t2;
		logic [255:0] s, r;
		for (int i = 0; i < 16; i++)
			w[i] = blk[511 - 32*i -: 32];
		for (int i = 16; i < 64; i++)
			w[i] = (ror(w[i-2], 17) ^ ror(w[i-2], 19) ^ (w[i-2] >> 10)) + w[i-7]
				+ (ror(w[i-15], 7) ^ ror(w[i-15], 18) ^ (w[i-15] >> 3)) + w[i-16];
		{a, b, c, d, e, f, g, hh} = h;
		for (int i = 0; i < 64; i++) begin
			t1 = hh + (ror(e, 6) ^ ror(e, 11) ^ ror(e, 25)) + ((e & f) ^ (~e & g))
				+ sha256_pkg::SHA_K[i] + w[i];
			t2 = (ror(a, 2) ^ ror(a, 13) ^ ror(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
			hh = g;
			g = f;
			f = e;
			e = d + t1;
			d = c;
			c = b;
			b = a;
			a = t1 + t2;
		end
		s = {a, b, c, d, e, f, g, hh};
		for (int j = 0; j < 8; j++)
			r[255 - 32*j -: 32] = h[255 - 32*j -: 32] + s[255 - 32*j -: 32];
		return r;
	endfunction

	// PBKDF2-HMAC-SHA256 of the header as password and salt over one iteration to 128 bytes
	function automatic logic [1023:0] expected_x(input logic [255:0] d1, input logic [255:0] d2,
			input logic [127:0] d3, input logic [31:0] nonce);
		logic [639:0] hdr;
		logic [255:0] key, istate, ostate, inner, t;
		logic [1023:0] x;
		for (int i = 0; i < 8; i++) begin
			hdr[639 - 32*i -: 32] = d1[32*i +: 32];	// Bus word 0 sits in the low bits
			hdr[383 - 32*i -: 32] = d2[32*i +: 32];
		end
		for (int i = 0; i < 3; i++)
			hdr[127 - 32*i -: 32] = d3[32*i +: 32];
		hdr[31:0] = nonce;	// Header word 19
		key = compress(IV_BE, hdr[639:128]);
		key = compress(key, {hdr[127:0], 32'h80000000, 320'd0, 32'd640});	// 80 bytes
		istate = compress(IV_BE, {key ^ {8{32'h36363636}}, {8{32'h36363636}}});
		istate = compress(istate, hdr[639:128]);
		ostate = compress(IV_BE, {key ^ {8{32'h5c5c5c5c}}, {8{32'h5c5c5c5c}}});
		for (int n = 1; n <= 4; n++) begin
			inner = compress(istate, {hdr[127:0], 32'(n), 32'h80000000, 288'd0, 32'd1184});
			t = compress(ostate, {inner, 32'h80000000, 192'd0, 32'd768});
			for (int i = 0; i < 8; i++)
				x[256*(n-1) + 32*i +: 32] = t[255 - 32*i -: 32];	// Block n with H0 lowest
		end
		return x;
	endfunction

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);	// One step per bit
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic check_value(input string name, input logic [1023:0] got,
			input logic [1023:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic apply_row(input int r);
		data1 = TAB_D1[r];
		data2 = TAB_D2[r];
		data3 = TAB_D3[r];
		nonce_msb = TAB_MSB[r];
		loadnonce = TAB_LOAD[r];
	endtask

	task automatic finish_run();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	initial begin
		hash_clk = 1'b0;
		forever #4 hash_clk = ~hash_clk;	// 8 ns period
	end

	initial begin
		while (cycles < CYCLE_LIMIT)
			@(posedge hash_clk) cycles++;
		$display("Timeout after %0d cycles, the salsa transfers did not all finish", cycles);
		errors++;
		finish_run();
	end

	initial begin
		logic [`XBUF_BITS-1:0] got_x, exp_x;
		int busy_len;
		reset = 1'b1;
		salsa_busy = 1'b0;
		apply_row(0);	// Row 0 load is ignored under reset
		repeat (5) @(negedge hash_clk);
		reset = 1'b0;
		check_value("salsa_shift", salsa_shift, 0);
		check_value("salsa_start", salsa_start, 0);
		check_value("nonce_out", nonce_out, TAB_NONCE[0]);
		for (int r = 0; r < ROWS; r++) begin
			exp_x = expected_x(TAB_D1[r], TAB_D2[r], TAB_D3[r], TAB_NONCE[r]);
			draw_bits(6, busy_len);	// Extra 0..63 cycles
			busy_len += TAB_HOLD[r];
			salsa_busy = 1'b1;
			repeat (busy_len) begin
				@(negedge hash_clk);
				check_value("salsa_shift", salsa_shift, 0);	// Held off by busy
				check_value("salsa_start", salsa_start, 0);	// Strobe lasts one cycle
			end
			salsa_busy = 1'b0;
			while (!salsa_shift)
				@(negedge hash_clk);
			check_value("nonce_out", nonce_out, TAB_NONCE[r] + 32'd1);	// Stepped at block 4
			for (int k = 0; k < `XBUF_BITS; k++) begin
				if (k == 0 && r + 1 < ROWS)
					apply_row(r + 1);	// Sequencer idles during the shift
				if (k == 1 && r + 1 < ROWS) begin
					loadnonce = 1'b0;
					check_value("nonce_out", nonce_out, TAB_NONCE[r + 1]);
				end
				check_value("salsa_shift", salsa_shift, 1);
				check_value("salsa_start", salsa_start, 0);
				got_x[`XBUF_BITS - 1 - k] = salsa_din;	// First bit is the MSB
				@(negedge hash_clk);
			end
			check_value("salsa_shift", salsa_shift, 0);
			check_value("salsa_start", salsa_start, 1);	// Strobe right after the shift
			check_value("salsa_din stream", got_x, exp_x);
		end
		finish_run();
	end

endmodule

/* verilog.f */
+incdir+.
sha256_pkg.sv
pbkdf_pkg.sv
hash_if.sv
sha256_core.sv
pbkdf_sequencer.sv
x_serializer.sv
pbkdf_engine.sv
tb_pbkdf_engine.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; exit status reflects the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_pbkdf_engine -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
	echo "Result: PASS"
	exit 0
fi
echo "Result: FAIL"
exit 1
